// File: design/video_config.svh
//######################################
// one SRAM word per address; SRAM_WAIT must be 1 or more
//######################################
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// word address width of the sprite SRAM
// 1M x 16 part on the board
`define SRAM_ADDR_W 20

// cycles that CE and OE stay low before the capture
// 2 covers a 10 ns part with margin at 50 MHz
`define SRAM_WAIT 2

// magenta, see-through in direct mode only
// indexed spans use index 0 instead
`define TRANSPARENT_KEY 16'hF81F

`endif

// File: design/pixelPkg.sv
//######################################
// pixel side types; palette is fixed greyscale
//######################################
`default_nettype none

package pixelPkg;

	// mode of a whole span
	typedef enum logic {DIRECT = 1'b0, INDEXED = 1'b1} pixMode_e;

	// red in the top bits, as the panel expects
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// one SRAM word, either one color or four nibble indices
	// idx[0] is the low nibble and is drawn first
	typedef union packed {
		rgb565_t rgb;
		logic [3:0][3:0] idx;
	} sramWord_u;

	// reader to unpacker
	typedef struct packed {
		sramWord_u data;
		pixMode_e mode;
		logic last;
	} wordBeat_t;

	// pixel leaving the fetch path
	typedef struct packed {
		logic [15:0] color;
		logic transparent;
		logic last;
	} pixel_t;

	// index stretched to each channel by repeating its top bits
	function automatic rgb565_t paletteColor(input logic [3:0] index);
		rgb565_t c;
		c.red = {index, index[3]};
		c.green = {index, index[3:2]};
		c.blue = {index, index[3]};
		return c;
	endfunction

endpackage

`default_nettype wire

// File: design/sramPkg.sv
//######################################
// SRAM side types; the SRAM is read only
//######################################
`default_nettype none

`include "video_config.svh"

package sramPkg;

	import pixelPkg::*;

	// span request from the drawing engine
	// count is in words and never zero
	typedef struct packed {
		logic [`SRAM_ADDR_W-1:0] base;
		logic [7:0] count;
		pixMode_e mode;
	} spanCmd_t;

	// pins to the SRAM; WE, UB and LB are tied on the board
	typedef struct packed {
		logic ceN;
		logic oeN;
		logic [`SRAM_ADDR_W-1:0] addr;
	} sramPins_t;

	// one word read, fetch stage to reader
	typedef struct packed {
		logic [`SRAM_ADDR_W-1:0] addr;
		pixMode_e mode;
		logic last;
	} readReq_t;

endpackage

`default_nettype wire

// File: design/spanFetch.sv
//######################################
// cmd must hold while spanReq is high
// spanAck waits for the last pixel out
//######################################
`default_nettype none
`timescale 1ns/1ps

module spanFetch (
	input  logic              Clk,
	input  logic              rstN,
	input  logic              spanReq,
	input  sramPkg::spanCmd_t cmd,
	output logic              spanAck,
	input  logic              spanDone,
	output logic              rdValid,
	input  logic              rdReady,
	output sramPkg::readReq_t rd
);
	import sramPkg::*;

	typedef enum logic [1:0] {Idle, Issue, Drain, Ack} state_e;

	state_e state;
	// base walks forward, count is words still to issue
	spanCmd_t cur;
	logic startSpan;
	logic lastWord;

	// spanAck is low in idle, so a high req here is a new span
	assign startSpan = (state == Idle) && spanReq;
	assign lastWord = (cur.count == 8'd1);

	assign spanAck = (state == Ack);
	assign rdValid = (state == Issue);
	assign rd = '{addr: cur.base, mode: cur.mode, last: lastWord};

	always_ff @(posedge Clk)
	begin
		if (!rstN)
			state <= Idle;
		else
		begin
			unique case (state)
				Idle:
					if (startSpan)
						state <= Issue;
				Issue:
					// final word taken, now wait for the pixels
					if (rdReady && lastWord)
						state <= Drain;
				Drain:
					if (spanDone)
						state <= Ack;
				Ack:
					// engine drops req, we drop ack
					if (!spanReq)
						state <= Idle;
				default:
					state <= Idle;
			endcase
		end
	end

	// address and count step only on an accepted read
	always_ff @(posedge Clk)
	begin
		if (startSpan)
			cur <= cmd;
		else if (rdValid && rdReady)
		begin
			cur.base <= cur.base + 1'b1;
			cur.count <= cur.count - 1'b1;
		end
	end

	// engine side of the four-phase handshake
	assert property (@(posedge Clk) disable iff (!rstN)
		spanReq && $past(spanReq) |-> $stable(cmd));

	// zero count would never raise last
	assert property (@(posedge Clk) disable iff (!rstN)
		spanReq |-> cmd.count != 8'd0);

endmodule

`default_nettype wire

// File: design/sramReader.sv
//######################################
// async SRAM read only; data sampled after SRAM_WAIT cycles
//######################################
`default_nettype none
`timescale 1ns/1ps

`include "video_config.svh"

module sramReader (
	input  logic                Clk,
	input  logic                rstN,
	input  logic                rdValid,
	output logic                rdReady,
	input  sramPkg::readReq_t   rd,
	output sramPkg::sramPins_t  sram,
	input  logic [15:0]         sramData,
	output logic                wordValid,
	input  logic                wordReady,
	output pixelPkg::wordBeat_t word
);
	import sramPkg::*;
	import pixelPkg::*;

	localparam int WaitW = $clog2(`SRAM_WAIT + 1);
	localparam logic [WaitW-1:0] WaitLast = WaitW'(`SRAM_WAIT - 1);

	typedef enum logic [1:0] {Idle, Access, Hold} state_e;

	state_e state;
	logic [WaitW-1:0] waitCnt;
	// request being served, address stays on the pins
	readReq_t req;
	wordBeat_t beat;
	logic take;
	logic capture;

	// a new request may enter on the same edge the held word leaves
	assign rdReady = (state == Idle) || ((state == Hold) && wordReady);
	assign take = rdValid && rdReady;
	// last cycle of the access window
	assign capture = (state == Access) && (waitCnt == WaitLast);

	assign wordValid = (state == Hold);
	assign word = beat;

	// chip selected and outputs enabled only during the access
	assign sram = '{ceN: (state != Access), oeN: (state != Access), addr: req.addr};

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			state <= Idle;
			waitCnt <= '0;
		end
		else
		begin
			if (take)
				waitCnt <= '0;
			else if (state == Access)
				waitCnt <= waitCnt + 1'b1;

			unique case (state)
				Idle:
					if (take)
						state <= Access;
				Access:
					if (capture)
						state <= Hold;
				Hold:
					// back to back when the fetch stage has one waiting
					if (wordReady)
						state <= take ? Access : Idle;
				default:
					state <= Idle;
			endcase
		end
	end

	always_ff @(posedge Clk)
	begin
		if (take)
			req <= rd;
		// mode and last ride along with the data
		if (capture)
		begin
			beat.data <= sramData;
			beat.mode <= req.mode;
			beat.last <= req.last;
		end
	end

	// bus contention guard on the shared data pins
	assert property (@(posedge Clk) disable iff (!rstN)
		!sram.oeN |-> !sram.ceN);

	// each access keeps OE low for exactly the wait window
	assert property (@(posedge Clk) disable iff (!rstN)
		$fell(sram.oeN) |-> !sram.oeN [*`SRAM_WAIT] ##1 sram.oeN);

endmodule

`default_nettype wire

// File: design/pixelUnpack.sv
//######################################
// one pixel per direct word, four per indexed word
//######################################
`default_nettype none
`timescale 1ns/1ps

`include "video_config.svh"

module pixelUnpack (
	input  logic                Clk,
	input  logic                rstN,
	input  logic                wordValid,
	output logic                wordReady,
	input  pixelPkg::wordBeat_t word,
	output logic                pixValid,
	input  logic                pixReady,
	output pixelPkg::pixel_t    pix,
	output logic                spanDone
);
	import pixelPkg::*;

	// word being unpacked
	wordBeat_t cur;
	logic full;
	// which nibble goes out next, low first
	logic [1:0] nib;
	logic [3:0] idx;
	logic finalPix;
	logic handOff;

	assign pixValid = full;
	assign handOff = pixValid && pixReady;
	assign finalPix = (cur.mode == DIRECT) || (nib == 2'd3);
	// refill while the final pixel of this word leaves
	assign wordReady = !full || (pixReady && finalPix);
	assign idx = cur.data.idx[nib];

	always_comb
	begin
		// only the closing pixel of the last word
		pix.last = cur.last && finalPix;
		if (cur.mode == DIRECT)
		begin
			pix.color = cur.data.rgb;
			pix.transparent = (cur.data.rgb == `TRANSPARENT_KEY);
		end
		else
		begin
			pix.color = paletteColor(idx);
			// index 0 is see-through
			pix.transparent = (idx == 4'd0);
		end
	end

	// tells the fetch stage the span has fully left
	assign spanDone = handOff && pix.last;

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			full <= 1'b0;
			nib <= 2'd0;
		end
		else if (wordValid && wordReady)
		begin
			full <= 1'b1;
			nib <= 2'd0;
		end
		else if (handOff && finalPix)
			full <= 1'b0;
		else if (handOff)
			nib <= nib + 1'b1;
	end

	always_ff @(posedge Clk)
	begin
		if (wordValid && wordReady)
			cur <= word;
	end

	// stalled pixel must not change under the sink
	assert property (@(posedge Clk) disable iff (!rstN)
		pixValid && !pixReady |=> pixValid && $stable(pix));

endmodule

`default_nettype wire

// File: design/spriteFetchTop.sv
//######################################
// span fetch path; latency varies, spanAck marks the end
//######################################
`default_nettype none
`timescale 1ns/1ps

module spriteFetchTop (
	input  logic               Clk,
	input  logic               rstN,
	input  logic               spanReq,
	input  sramPkg::spanCmd_t  cmd,
	output logic               spanAck,
	output sramPkg::sramPins_t sram,
	input  logic [15:0]        sramData,
	output logic               pixValid,
	input  logic               pixReady,
	output pixelPkg::pixel_t   pix
);
	import sramPkg::*;
	import pixelPkg::*;

	// fetch to reader
	logic rdValid;
	logic rdReady;
	readReq_t rd;
	// reader to unpacker
	logic wordValid;
	logic wordReady;
	wordBeat_t word;
	// unpacker back to fetch
	logic spanDone;

	spanFetch i_spanFetch (
		.Clk      (Clk),
		.rstN     (rstN),
		.spanReq  (spanReq),
		.cmd      (cmd),
		.spanAck  (spanAck),
		.spanDone (spanDone),
		.rdValid  (rdValid),
		.rdReady  (rdReady),
		.rd       (rd)
	);

	sramReader i_sramReader (
		.Clk       (Clk),
		.rstN      (rstN),
		.rdValid   (rdValid),
		.rdReady   (rdReady),
		.rd        (rd),
		.sram      (sram),
		.sramData  (sramData),
		.wordValid (wordValid),
		.wordReady (wordReady),
		.word      (word)
	);

	pixelUnpack i_pixelUnpack (
		.Clk       (Clk),
		.rstN      (rstN),
		.wordValid (wordValid),
		.wordReady (wordReady),
		.word      (word),
		.pixValid  (pixValid),
		.pixReady  (pixReady),
		.pix       (pix),
		.spanDone  (spanDone)
	);

endmodule

`default_nettype wire

// File: verif/sramModel.sv
//######################################
// read-only async SRAM; word = addr[15:0] ^ A5C3
// data is X unless CE and OE are both low
//######################################
`default_nettype none
`timescale 1ns/1ps

module sramModel #(
	// address to data delay of the part
	parameter int AccessNs = 8
) (
	input  sramPkg::sramPins_t sram,
	output logic [15:0]        data
);

	logic [15:0] romWord;
	logic selected;

	// content is a fixed formula of the address
	assign romWord = sram.addr[15:0] ^ 16'hA5C3;
	assign selected = !sram.ceN && !sram.oeN;

	// outputs float while deselected, shown as X
	assign #(AccessNs) data = selected ? romWord : 16'hxxxx;

endmodule

`default_nettype wire

// File: verif/tbSpriteFetch.sv
//######################################
// directed tests; inputs change on rising edges
// outputs sampled on falling edges
//######################################
`default_nettype none
`timescale 1ns/1ps

`include "video_config.svh"

module tbSpriteFetch;
	import pixelPkg::*;
	import sramPkg::*;

	// words over all spans, sets the run limit
	localparam int TotalWords = 8 + 5 + 4 + 16 + 16 + 6 + 3;
	localparam int TimeoutLimit = TotalWords * (`SRAM_WAIT + 5) + 2000;

	logic Clk;
	logic rstN;
	logic spanReq;
	spanCmd_t cmd;
	logic spanAck;
	sramPins_t sram;
	logic [15:0] sramData;
	logic pixValid;
	logic pixReady;
	pixel_t pix;

	pixel_t gotQ[$];
	pixel_t expQ[$];
	int mismatchCount = 0;
	int failCount = 0;
	int cycleCount = 0;
	int stallCycles = 0;
	integer seed = 32'h4135;
	logic [31:0] rndWord;
	logic readyRandom;
	logic lastSeen;

	spriteFetchTop i_spriteFetchTop (
		.Clk      (Clk),
		.rstN     (rstN),
		.spanReq  (spanReq),
		.cmd      (cmd),
		.spanAck  (spanAck),
		.sram     (sram),
		.sramData (sramData),
		.pixValid (pixValid),
		.pixReady (pixReady),
		.pix      (pix)
	);

	sramModel i_sramModel (
		.sram (sram),
		.data (sramData)
	);

	initial
	begin
		Clk = 1'b0;
		forever #10 Clk = ~Clk;
	end

	// sink ready, random only in the back-pressure test
	always @(posedge Clk)
	begin
		rndWord = $random(seed);
		pixReady <= readyRandom ? rndWord[0] : 1'b1;
	end

	// pixel collector and bus monitors
	always @(negedge Clk)
	begin
		if (rstN)
		begin
			if (pixValid && pixReady)
			begin
				gotQ.push_back(pix);
				if (pix.last)
					lastSeen = 1'b1;
			end
			if (pixValid && !pixReady)
				stallCycles++;
			if (spanAck && !lastSeen)
				reportFailure("spanAck rose before the last pixel was taken");
			if (!sram.oeN && sram.ceN)
				reportFailure("SRAM output enable was low while chip enable was high");
		end
	end

	// run limit
	always @(posedge Clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutLimit)
		begin
			$display("Timeout after %0d cycles, a span never completed", cycleCount);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic reportMismatch(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		$display("Mismatch in %s, %s: expected %h, actual %h", name, what, expected, actual);
		mismatchCount++;
	endtask

	task automatic reportFailure(input string msg);
		$display("Failure: %s", msg);
		failCount++;
	endtask

	// bits of v repeated from the top to fill width
	function automatic logic [5:0] stretchBits(input logic [3:0] v, input int width);
		logic [5:0] r;
		r = '0;
		for (int i = 0; i < width; i++)
			r[width-1-i] = v[3 - (i % 4)];
		return r;
	endfunction

	function automatic logic [15:0] paletteExpect(input logic [3:0] idx);
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		r = stretchBits(idx, 5);
		g = stretchBits(idx, 6);
		b = stretchBits(idx, 5);
		return {r[4:0], g, b[4:0]};
	endfunction

	// expected pixels straight from the ROM formula
	task automatic buildExpected(input logic [19:0] base, input int count,
		input pixMode_e mode);
		logic [15:0] w;
		logic [3:0] idx;
		pixel_t p;
		expQ.delete();
		for (int k = 0; k < count; k++)
		begin
			w = (base[15:0] + k[15:0]) ^ 16'hA5C3;
			if (mode == DIRECT)
			begin
				p = '{color: w, transparent: (w == `TRANSPARENT_KEY), last: (k == count - 1)};
				expQ.push_back(p);
			end
			else
			begin
				// low nibble first
				for (int n = 0; n < 4; n++)
				begin
					idx = w[4*n +: 4];
					p = '{color: paletteExpect(idx), transparent: (idx == 4'd0),
						last: (k == count - 1) && (n == 3)};
					expQ.push_back(p);
				end
			end
		end
	endtask

	// one four-phase span; holdCycles keeps req high after ack
	task automatic runSpan(input logic [19:0] base, input logic [7:0] count,
		input pixMode_e mode, input int holdCycles);
		@(posedge Clk);
		gotQ.delete();
		lastSeen = 1'b0;
		cmd <= '{base: base, count: count, mode: mode};
		spanReq <= 1'b1;
		do
			@(negedge Clk);
		while (!spanAck);
		repeat (holdCycles)
		begin
			@(negedge Clk);
			if (!spanAck)
				reportFailure("spanAck fell while spanReq was still high");
		end
		@(posedge Clk);
		spanReq <= 1'b0;
		do
			@(negedge Clk);
		while (spanAck);
	endtask

	task automatic checkPixels(input string name);
		if (gotQ.size() != expQ.size())
			reportMismatch(name, "pixel count", expQ.size(), gotQ.size());
		for (int i = 0; i < expQ.size() && i < gotQ.size(); i++)
			if (gotQ[i] !== expQ[i])
				reportMismatch(name, $sformatf("pixel %0d", i), expQ[i], gotQ[i]);
	endtask

	task automatic testResetState;
		@(negedge Clk);
		if (spanAck !== 1'b0)
			reportMismatch("reset state", "spanAck", 0, spanAck);
		if (pixValid !== 1'b0)
			reportMismatch("reset state", "pixValid", 0, pixValid);
		if (sram.ceN !== 1'b1)
			reportMismatch("reset state", "ceN", 1, sram.ceN);
		if (sram.oeN !== 1'b1)
			reportMismatch("reset state", "oeN", 1, sram.oeN);
	endtask

	task automatic testDirectSpan;
		buildExpected(20'h00100, 8, DIRECT);
		runSpan(20'h00100, 8'd8, DIRECT, 0);
		checkPixels("direct span");
	endtask

	task automatic testIndexedSpan;
		// 0x2343 reads back 0x8680, so one zero nibble
		buildExpected(20'h02340, 5, INDEXED);
		runSpan(20'h02340, 8'd5, INDEXED, 0);
		checkPixels("indexed span");
	endtask

	task automatic testTransparentKey;
		// low half 5DDC reads back F81F, third word of the span
		buildExpected(20'h15DDA, 4, DIRECT);
		runSpan(20'h15DDA, 8'd4, DIRECT, 0);
		checkPixels("transparency key");
		if (gotQ.size() > 2 && gotQ[2].transparent !== 1'b1)
			reportMismatch("transparency key", "key pixel flag", 1, gotQ[2].transparent);
	endtask

	task automatic testBackPressure;
		pixel_t refQ[$];
		buildExpected(20'h00800, 16, INDEXED);
		runSpan(20'h00800, 8'd16, INDEXED, 0);
		checkPixels("back-pressure ready high");
		refQ = gotQ;
		stallCycles = 0;
		readyRandom = 1'b1;
		runSpan(20'h00800, 8'd16, INDEXED, 0);
		readyRandom = 1'b0;
		checkPixels("back-pressure random ready");
		if (stallCycles == 0)
			reportFailure("pixReady never stalled a valid pixel");
		if (gotQ.size() != refQ.size())
			reportMismatch("back-pressure replay", "pixel count", refQ.size(), gotQ.size());
		for (int i = 0; i < refQ.size() && i < gotQ.size(); i++)
			if (gotQ[i] !== refQ[i])
				reportMismatch("back-pressure replay", $sformatf("pixel %0d", i), refQ[i], gotQ[i]);
	endtask

	task automatic testHandshake;
		// engine is slow to drop req on the first span
		buildExpected(20'h04000, 6, DIRECT);
		runSpan(20'h04000, 8'd6, DIRECT, 3);
		checkPixels("handshake first span");
		buildExpected(20'h04100, 3, INDEXED);
		runSpan(20'h04100, 8'd3, INDEXED, 0);
		checkPixels("handshake second span");
	endtask

	initial
	begin
		rstN = 1'b0;
		spanReq = 1'b0;
		cmd = '0;
		pixReady = 1'b0;
		readyRandom = 1'b0;
		lastSeen = 1'b0;
		repeat (10) @(posedge Clk);
		rstN <= 1'b1;
		testResetState();
		testDirectSpan();
		testIndexedSpan();
		testTransparentKey();
		testBackPressure();
		testHandshake();
		repeat (5) @(posedge Clk);
		$display("Done: %0d mismatches, %0d other errors", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/pixelPkg.sv
design/sramPkg.sv
design/spanFetch.sv
design/sramReader.sv
design/pixelUnpack.sv
design/spriteFetchTop.sv
verif/sramModel.sv
verif/tbSpriteFetch.sv

// File: Bender.yml
package:
  name: sprite_fetch

sources:
  - include_dirs:
      - design
    files:
      - design/pixelPkg.sv
      - design/sramPkg.sv
      - design/spanFetch.sv
      - design/sramReader.sv
      - design/pixelUnpack.sv
      - design/spriteFetchTop.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/sramModel.sv
      - verif/tbSpriteFetch.sv
